// ==== Bender.yml ====
package:
  name: mem_event_monitor

sources:
  - src/soc_addr_pkg.sv
  - src/pmu_event_pkg.sv
  - src/addr_rule_match.sv
  - src/event_classify.sv
  - src/event_counter_bank.sv
  - src/pmu_cfg_port.sv
  - src/mem_event_monitor.sv
  - target: test
    files:
      - tb/tb_mem_event_monitor.sv

// ==== all.f ====
src/soc_addr_pkg.sv
src/pmu_event_pkg.sv
src/addr_rule_match.sv
src/event_classify.sv
src/event_counter_bank.sv
src/pmu_cfg_port.sv
src/mem_event_monitor.sv
tb/tb_mem_event_monitor.sv

// ==== src/addr_rule_match.sv ====
module addr_rule_match (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  pmu_event_pkg::mem_access_t     access_i,
  output pmu_event_pkg::matched_access_t matched_o
);

  import soc_addr_pkg::*;

  logic [NumAddrRules-1:0] rule_hit;
  logic                    match_found;
  region_idx_t             match_idx;

  always_comb begin
    for (int unsigned i = 0; i < NumAddrRules; i++) begin
      rule_hit[i] = (access_i.addr >= AddrMap[i].start_addr) &&
                    (access_i.addr <  AddrMap[i].end_addr);
    end
  end

  // Walk downwards so the lowest matching rule wins
  always_comb begin
    match_found = 1'b0;
    match_idx   = '0;
    for (int i = NumAddrRules - 1; i >= 0; i--) begin
      if (rule_hit[i]) begin
        match_found = 1'b1;
        match_idx   = AddrMap[i].idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    matched_o.write   <= access_i.write;
    matched_o.hit     <= access_i.hit;
    matched_o.matched <= match_found;
    matched_o.region  <= match_idx;
    if (reset_i) begin
      matched_o.valid <= 1'b0;
    end else begin
      matched_o.valid <= access_i.valid;
    end
  end

endmodule

// ==== src/event_classify.sv ====
module event_classify (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  pmu_event_pkg::matched_access_t matched_i,
  output pmu_event_pkg::event_vec_t      events_o
);

  import pmu_event_pkg::*;
  import soc_addr_pkg::*;

  event_vec_t events_d;

  always_comb begin
    events_d = '0;
    if (matched_i.valid) begin
      // One of the four cache outcomes
      unique case ({matched_i.write, matched_i.hit})
        2'b01:   events_d[EvReadHit]   = 1'b1;
        2'b00:   events_d[EvReadMiss]  = 1'b1;
        2'b11:   events_d[EvWriteHit]  = 1'b1;
        default: events_d[EvWriteMiss] = 1'b1;
      endcase

      if (!matched_i.matched) begin
        events_d[EvUnmapped] = 1'b1;
      end else if (matched_i.region == AddrMap[1].idx) begin
        events_d[EvHyperRegion] = 1'b1;
      end else begin
        events_d[EvDebugRegion] = 1'b1;
      end

      events_d[EvTotal] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      events_o <= '0;
    end else begin
      events_o <= events_d;
    end
  end

endmodule

// ==== src/event_counter_bank.sv ====
module event_counter_bank (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  pmu_event_pkg::event_vec_t events_i,
  input  logic                      reg_we_i,
  input  logic                      reg_re_i,
  input  pmu_event_pkg::reg_addr_t  reg_addr_i,
  input  pmu_event_pkg::reg_data_t  reg_wdata_i,
  output pmu_event_pkg::reg_data_t  reg_rdata_o,
  output logic                      irq_o
);

  import pmu_event_pkg::*;

  cnt_t [NumCounter-1:0] cnt_q;
  cnt_t [NumCounter-1:0] cnt_inc;
  cnt_t                  threshold_q;
  event_vec_t            enable_q;
  event_vec_t            irq_status_q;

  event_vec_t cnt_wr;
  event_vec_t cnt_en;
  event_vec_t irq_set;
  event_vec_t irq_clr;
  logic       thr_wr;
  logic       en_wr;

  // Word decode of the register write
  always_comb begin
    for (int unsigned i = 0; i < NumCounter; i++) begin
      cnt_wr[i] = reg_we_i && (reg_addr_i == reg_addr_t'(i));
    end
  end

  assign thr_wr  = reg_we_i && (reg_addr_i == RegThreshold);
  assign en_wr   = reg_we_i && (reg_addr_i == RegEnable);
  assign irq_clr = (reg_we_i && (reg_addr_i == RegIrqStatus)) ?
                   reg_wdata_i[NumCounter-1:0] : '0;

  // A register write to the same counter takes priority
  always_comb begin
    for (int unsigned i = 0; i < NumCounter; i++) begin
      cnt_en[i]  = events_i[i] && enable_q[i] && !cnt_wr[i];
      cnt_inc[i] = cnt_q[i] + cnt_t'(1);
      irq_set[i] = cnt_en[i] && (threshold_q != '0) && (cnt_inc[i] == threshold_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q        <= '0;
      threshold_q  <= '0;
      enable_q     <= '1;
      irq_status_q <= '0;
    end else begin
      for (int unsigned i = 0; i < NumCounter; i++) begin
        if (cnt_wr[i]) begin
          cnt_q[i] <= reg_wdata_i;
        end else if (cnt_en[i]) begin
          cnt_q[i] <= cnt_inc[i];
        end
      end
      if (thr_wr) begin
        threshold_q <= reg_wdata_i;
      end
      if (en_wr) begin
        enable_q <= reg_wdata_i[NumCounter-1:0];
      end
      // Write-one-to-clear beats a new set
      irq_status_q <= (irq_status_q | irq_set) & ~irq_clr;
    end
  end

  assign irq_o = |irq_status_q;

  // Zero unless a read is strobed
  always_comb begin
    reg_rdata_o = '0;
    if (reg_re_i) begin
      for (int unsigned i = 0; i < NumCounter; i++) begin
        if (reg_addr_i == reg_addr_t'(i)) begin
          reg_rdata_o = cnt_q[i];
        end
      end
      if (reg_addr_i == RegThreshold) begin
        reg_rdata_o = threshold_q;
      end
      if (reg_addr_i == RegIrqStatus) begin
        reg_rdata_o = reg_data_t'(irq_status_q);
      end
      if (reg_addr_i == RegEnable) begin
        reg_rdata_o = reg_data_t'(enable_q);
      end
    end
  end

endmodule

// ==== src/mem_event_monitor.sv ====
module mem_event_monitor (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  pmu_event_pkg::mem_access_t access_i,
  input  logic                       cfg_valid_i,
  input  pmu_event_pkg::cfg_req_t    cfg_req_i,
  output logic                       cfg_ready_o,
  output logic                       cfg_rsp_valid_o,
  output pmu_event_pkg::cfg_rsp_t    cfg_rsp_o,
  input  logic                       cfg_rsp_ready_i,
  output logic                       irq_o
);

  import pmu_event_pkg::*;

  matched_access_t matched;
  event_vec_t      events;
  logic            reg_we;
  logic            reg_re;
  reg_addr_t       reg_addr;
  reg_data_t       reg_wdata;
  reg_data_t       reg_rdata;

  addr_rule_match i_addr_rule_match (
    .clk_i     ( clk_i    ),
    .reset_i   ( reset_i  ),
    .access_i  ( access_i ),
    .matched_o ( matched  )
  );

  event_classify i_event_classify (
    .clk_i     ( clk_i    ),
    .reset_i   ( reset_i  ),
    .matched_i ( matched  ),
    .events_o  ( events   )
  );

  event_counter_bank i_event_counter_bank (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .events_i    ( events    ),
    .reg_we_i    ( reg_we    ),
    .reg_re_i    ( reg_re    ),
    .reg_addr_i  ( reg_addr  ),
    .reg_wdata_i ( reg_wdata ),
    .reg_rdata_o ( reg_rdata ),
    .irq_o       ( irq_o     )
  );

  pmu_cfg_port i_pmu_cfg_port (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .cfg_valid_i     ( cfg_valid_i     ),
    .cfg_req_i       ( cfg_req_i       ),
    .cfg_ready_o     ( cfg_ready_o     ),
    .cfg_rsp_valid_o ( cfg_rsp_valid_o ),
    .cfg_rsp_o       ( cfg_rsp_o       ),
    .cfg_rsp_ready_i ( cfg_rsp_ready_i ),
    .reg_we_o        ( reg_we          ),
    .reg_re_o        ( reg_re          ),
    .reg_addr_o      ( reg_addr        ),
    .reg_wdata_o     ( reg_wdata       ),
    .reg_rdata_i     ( reg_rdata       )
  );

endmodule

// ==== src/pmu_cfg_port.sv ====
module pmu_cfg_port (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     cfg_valid_i,
  input  pmu_event_pkg::cfg_req_t  cfg_req_i,
  output logic                     cfg_ready_o,
  output logic                     cfg_rsp_valid_o,
  output pmu_event_pkg::cfg_rsp_t  cfg_rsp_o,
  input  logic                     cfg_rsp_ready_i,
  output logic                     reg_we_o,
  output logic                     reg_re_o,
  output pmu_event_pkg::reg_addr_t reg_addr_o,
  output pmu_event_pkg::reg_data_t reg_wdata_o,
  input  pmu_event_pkg::reg_data_t reg_rdata_i
);

  import pmu_event_pkg::*;

  cfg_state_e state_q;
  cfg_state_e state_d;
  reg_data_t  rdata_q;
  logic       req_fire;

  assign cfg_ready_o = (state_q == CfgIdle);
  assign req_fire    = cfg_valid_i && cfg_ready_o;

  // Single-cycle strobe towards the counter bank
  assign reg_we_o    = req_fire && cfg_req_i.write;
  assign reg_re_o    = req_fire && !cfg_req_i.write;
  assign reg_addr_o  = cfg_req_i.addr;
  assign reg_wdata_o = cfg_req_i.wdata;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      CfgIdle: begin
        if (req_fire) begin
          state_d = CfgResp;
        end
      end
      CfgResp: begin
        if (cfg_rsp_ready_i) begin
          state_d = CfgIdle;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= CfgIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // The bank drives zero without a read strobe, so writes answer zero
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rdata_q <= reg_rdata_i;
    end
  end

  assign cfg_rsp_valid_o = (state_q == CfgResp);
  assign cfg_rsp_o.rdata = rdata_q;

endmodule

// ==== src/pmu_event_pkg.sv ====
package pmu_event_pkg;

  localparam int unsigned NumCounter = 8;
  localparam int unsigned CntWidth   = 32;

  typedef logic [CntWidth-1:0]   cnt_t;
  typedef logic [NumCounter-1:0] event_vec_t;
  typedef logic [31:0]           reg_data_t;

  // Bit positions in the event vector, one counter each
  localparam int unsigned EvReadHit     = 0;
  localparam int unsigned EvReadMiss    = 1;
  localparam int unsigned EvWriteHit    = 2;
  localparam int unsigned EvWriteMiss   = 3;
  localparam int unsigned EvDebugRegion = 4;
  localparam int unsigned EvHyperRegion = 5;
  localparam int unsigned EvUnmapped    = 6;
  localparam int unsigned EvTotal       = 7;

  typedef struct packed {
    logic                valid;
    logic                write;
    logic                hit;
    soc_addr_pkg::addr_t addr;
  } mem_access_t;

  typedef struct packed {
    logic                      valid;
    logic                      write;
    logic                      hit;
    logic                      matched;
    soc_addr_pkg::region_idx_t region;
  } matched_access_t;

  localparam int unsigned RegAddrWidth = 4;

  typedef logic [RegAddrWidth-1:0] reg_addr_t;

  // Words 0 to 7 hold the counters
  localparam reg_addr_t RegThreshold = 4'd8;
  localparam reg_addr_t RegIrqStatus = 4'd9;
  localparam reg_addr_t RegEnable    = 4'd10;

  typedef struct packed {
    logic      write;
    reg_addr_t addr;
    reg_data_t wdata;
  } cfg_req_t;

  typedef struct packed {
    reg_data_t rdata;
  } cfg_rsp_t;

  typedef enum logic {
    CfgIdle,
    CfgResp
  } cfg_state_e;

endpackage

// ==== src/soc_addr_pkg.sv ====
package soc_addr_pkg;

  localparam int unsigned AddrWidth = 64;

  typedef logic [AddrWidth-1:0] addr_t;

  localparam int unsigned NumAddrRules = 2;

  typedef logic [$clog2(NumAddrRules)-1:0] region_idx_t;

  // End address is exclusive
  typedef struct packed {
    region_idx_t idx;
    addr_t       start_addr;
    addr_t       end_addr;
  } addr_rule_t;

  localparam addr_t DebugBase   = 64'h0000_0000_0000_0000;
  localparam addr_t HyperBase   = 64'h0000_0000_8000_0000;
  localparam addr_t HyperLength = 64'h0000_0000_4000_0000;

  // Rule 0 is the debug window, rule 1 the HyperRAM window
  localparam addr_rule_t AddrMap [NumAddrRules] = '{
    '{
      idx:        region_idx_t'(0),
      start_addr: DebugBase,
      end_addr:   HyperBase
    },
    '{
      idx:        region_idx_t'(1),
      start_addr: HyperBase,
      end_addr:   HyperBase + HyperLength
    }
  };

endpackage

// ==== tb/tb_mem_event_monitor.sv ====
module tb_mem_event_monitor;

  timeunit 1ns;
  timeprecision 1ps;

  import soc_addr_pkg::*;
  import pmu_event_pkg::*;

  // Cycle budgets of the six tests, in test order
  localparam int unsigned CycleBudget = 100 + 900 + 300 + 150 + 200 + 100;

  logic        clk_i = 1'b0;
  logic        reset_i;
  mem_access_t access_i;
  logic        cfg_valid_i;
  cfg_req_t    cfg_req_i;
  logic        cfg_ready_o;
  logic        cfg_rsp_valid_o;
  cfg_rsp_t    cfg_rsp_o;
  logic        cfg_rsp_ready_i;
  logic        irq_o;

  // Reference model state
  cnt_t       model_cnt [NumCounter];
  cnt_t       model_thr;
  event_vec_t model_en;
  event_vec_t model_sts;

  int unsigned errors = 0;
  int unsigned err_mark = 0;
  int unsigned tests_passed = 0;
  int unsigned tests_failed = 0;

  mem_event_monitor mem_event_monitor_i (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .access_i        ( access_i        ),
    .cfg_valid_i     ( cfg_valid_i     ),
    .cfg_req_i       ( cfg_req_i       ),
    .cfg_ready_o     ( cfg_ready_o     ),
    .cfg_rsp_valid_o ( cfg_rsp_valid_o ),
    .cfg_rsp_o       ( cfg_rsp_o       ),
    .cfg_rsp_ready_i ( cfg_rsp_ready_i ),
    .irq_o           ( irq_o           )
  );

  always #5 clk_i = ~clk_i;

  a_ready_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    cfg_ready_o == !cfg_rsp_valid_o)
    else begin
      errors++;
      $display("Config port accepts requests while a response is pending");
    end

  a_rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    cfg_rsp_valid_o && !cfg_rsp_ready_i |=> cfg_rsp_valid_o && $stable(cfg_rsp_o.rdata))
    else begin
      errors++;
      $display("Response dropped or changed before it was accepted");
    end

  task automatic check_value(input string name, input reg_data_t exp, input reg_data_t act);
    a_value: assert (act === exp)
      else begin
        errors++;
        $display("[ERROR] %s expected %08h got %08h", name, exp, act);
      end
  endtask

  task automatic wait_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // Offer, when set, presents a stray write while the response is held
  task automatic cfg_xfer(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
                          input int unsigned hold, input logic offer,
                          output reg_data_t rdata);
    cfg_valid_i = 1'b1;
    cfg_req_i   = '{write: wr, addr: addr, wdata: wdata};
    while (!cfg_ready_o) begin
      wait_cycles(1);
    end
    wait_cycles(1);
    cfg_valid_i = 1'b0;
    a_rsp_seen: assert (cfg_rsp_valid_o)
      else begin
        errors++;
        $display("No response one cycle after the request was accepted");
      end
    repeat (hold) begin
      if (offer) begin
        cfg_valid_i = 1'b1;
        cfg_req_i   = '{write: 1'b1, addr: RegThreshold, wdata: 32'hdead_beef};
      end
      wait_cycles(1);
    end
    cfg_valid_i     = 1'b0;
    cfg_rsp_ready_i = 1'b1;
    rdata           = cfg_rsp_o.rdata;
    wait_cycles(1);
    cfg_rsp_ready_i = 1'b0;
  endtask

  task automatic cfg_read(input reg_addr_t addr, output reg_data_t rdata);
    cfg_xfer(1'b0, addr, '0, 0, 1'b0, rdata);
  endtask

  task automatic cfg_write(input reg_addr_t addr, input reg_data_t data);
    reg_data_t rd;
    cfg_xfer(1'b1, addr, data, 0, 1'b0, rd);
    check_value("cfg_rsp_o", '0, rd);
    if (addr < NumCounter) begin
      model_cnt[addr] = data;
    end else if (addr == RegThreshold) begin
      model_thr = data;
    end else if (addr == RegIrqStatus) begin
      model_sts = model_sts & ~data[NumCounter-1:0];
    end else if (addr == RegEnable) begin
      model_en = data[NumCounter-1:0];
    end
  endtask

  task automatic expect_reg(input string name, input reg_addr_t addr, input reg_data_t exp);
    reg_data_t rd;
    cfg_read(addr, rd);
    check_value(name, exp, rd);
  endtask

  // Debug below 0x8000_0000, HyperRAM up to 0xC000_0000, unmapped above
  function automatic event_vec_t expected_events(input logic wr, input logic hit,
                                                 input addr_t addr);
    event_vec_t ev;
    ev = '0;
    if (wr) begin
      ev[hit ? EvWriteHit : EvWriteMiss] = 1'b1;
    end else begin
      ev[hit ? EvReadHit : EvReadMiss] = 1'b1;
    end
    if (addr < 64'h8000_0000) begin
      ev[EvDebugRegion] = 1'b1;
    end else if (addr < 64'hC000_0000) begin
      ev[EvHyperRegion] = 1'b1;
    end else begin
      ev[EvUnmapped] = 1'b1;
    end
    ev[EvTotal] = 1'b1;
    return ev;
  endfunction

  function automatic void model_count(input event_vec_t ev);
    for (int i = 0; i < NumCounter; i++) begin
      if (ev[i] && model_en[i]) begin
        model_cnt[i] = model_cnt[i] + cnt_t'(1);
        if (model_thr != '0 && model_cnt[i] == model_thr) begin
          model_sts[i] = 1'b1;
        end
      end
    end
  endfunction

  function automatic addr_t random_addr();
    case ($urandom_range(0, 2))
      0:       return {32'h0, $urandom() & 32'h7fff_ffff};
      1:       return {32'h0, 32'h8000_0000 | ($urandom() & 32'h3fff_ffff)};
      default: begin
        if ($urandom_range(0, 1) == 0) begin
          return {32'h0, 32'hc000_0000 | ($urandom() & 32'h3fff_ffff)};
        end
        return {$urandom() | 32'h1, $urandom()};
      end
    endcase
  endfunction

  task automatic drive_access(input logic wr, input logic hit, input addr_t addr);
    access_i = '{valid: 1'b1, write: wr, hit: hit, addr: addr};
    model_count(expected_events(wr, hit, addr));
    wait_cycles(1);
    access_i.valid = 1'b0;
  endtask

  // Idle cycles are mixed in at random
  task automatic run_traffic(input int unsigned n);
    for (int unsigned k = 0; k < n; k++) begin
      if ($urandom_range(0, 3) == 0) begin
        wait_cycles(1);
      end else begin
        drive_access($urandom_range(0, 1), $urandom_range(0, 1), random_addr());
      end
    end
  endtask

  task automatic check_counters();
    reg_data_t rd;
    wait_cycles(4);
    for (int i = 0; i < NumCounter; i++) begin
      cfg_read(reg_addr_t'(i), rd);
      check_value($sformatf("counter[%0d]", i), model_cnt[i], rd);
    end
    check_value("irq_o", reg_data_t'(|model_sts), reg_data_t'(irq_o));
  endtask

  task automatic finish_test(input string name);
    if (errors == err_mark) begin
      tests_passed++;
      $display("test %-20s ok", name);
    end else begin
      tests_failed++;
      $display("test %-20s failed with %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  initial begin
    #(CycleBudget * 2 * 10);
    $display("Timeout: the run exceeded its cycle budget");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    int unsigned n;
    reg_data_t   rd;
    void'($urandom(32'h5753_da67));
    reset_i         = 1'b1;
    access_i        = '0;
    cfg_valid_i     = 1'b0;
    cfg_req_i       = '0;
    cfg_rsp_ready_i = 1'b0;
    foreach (model_cnt[i]) begin
      model_cnt[i] = '0;
    end
    model_thr = '0;
    model_en  = '1;
    model_sts = '0;
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    check_value("irq_o", '0, reg_data_t'(irq_o));
    check_value("cfg_rsp_valid_o", '0, reg_data_t'(cfg_rsp_valid_o));
    check_value("cfg_ready_o", 32'h1, reg_data_t'(cfg_ready_o));
    check_counters();
    expect_reg("threshold", RegThreshold, '0);
    expect_reg("enable", RegEnable, 32'hff);
    finish_test("reset");

    run_traffic(300);
    check_counters();
    finish_test("random_traffic");

    // Hit and miss counters frozen, region counters keep going
    cfg_write(RegEnable, 32'hf0);
    run_traffic(40);
    check_counters();
    cfg_write(4'd2, 32'h1234_5678);
    expect_reg("counter[2]", 4'd2, 32'h1234_5678);
    cfg_write(4'd7, 32'hffff_ffff);
    cfg_write(RegEnable, 32'hff);
    drive_access(1'b1, 1'b0, random_addr());
    check_counters();
    finish_test("enable_and_load");

    n = $urandom_range(3, 10);
    cfg_write(RegEnable, 32'h02);
    cfg_write(4'd1, '0);
    cfg_write(RegThreshold, n);
    repeat (n) begin
      drive_access(1'b0, 1'b0, random_addr());
    end
    wait_cycles(4);
    check_value("irq_o", 32'h1, reg_data_t'(irq_o));
    expect_reg("irq_status", RegIrqStatus, 32'h2);
    cfg_write(RegIrqStatus, 32'h2);
    check_value("irq_o", '0, reg_data_t'(irq_o));
    cfg_write(RegThreshold, '0);
    cfg_write(RegEnable, 32'hff);
    finish_test("threshold_irq");

    for (int k = 0; k < 6; k++) begin
      cfg_xfer(1'b0, reg_addr_t'(k), '0, $urandom_range(1, 8), 1'b1, rd);
      check_value($sformatf("counter[%0d]", k), model_cnt[k], rd);
      expect_reg("threshold", RegThreshold, model_thr);
    end
    finish_test("rsp_backpressure");

    cfg_write(4'd12, 32'hffff_ffff);
    for (int a = 11; a < 16; a++) begin
      expect_reg($sformatf("reg[%0d]", a), reg_addr_t'(a), '0);
    end
    check_counters();
    finish_test("latency_unused");

    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
